//--- build.f
+incdir+testbench
src/noc_pkg.sv
src/mem_pkg.sv
src/noc_credit_in.sv
src/noc_credit_out.sv
src/mem_store.sv
src/mem_ctrl_fsm.sv
src/fake_mem_top.sv
testbench/tb_fake_mem.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fake memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f build.f \
    --top-module tb_fake_mem -o sim_fake_mem

out=$(./obj_dir/sim_fake_mem 2>&1 || true)
echo "$out"

if grep -q "RESULT: PASS" <<< "$out"; then
    exit 0
fi
exit 1

//--- src/fake_mem_top.sv
// fake memory controller top, credit links around the controller and array
// request link in (noc2 style), reply link out (noc3 style)

module fake_mem_top #(
    parameter int BUF_DEPTH = 4,     // receive buffer and link credits
    parameter int MEM_DEPTH = 256    // 64 bit words, power of two
) (
    input  logic                          chip,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic [noc_pkg::FLIT_WIDTH-1:0] req_data,
    output logic                          req_yummy,
    output logic                          rsp_valid,
    output logic [noc_pkg::FLIT_WIDTH-1:0] rsp_data,
    input  logic                          rsp_yummy
);

    localparam int ADDR_W = $clog2(MEM_DEPTH);

    ////////////////////
    // internal val/rdy
    ////////////////////
    logic                          rx_valid;
    logic [noc_pkg::FLIT_WIDTH-1:0] rx_data;
    logic                          rx_ready;
    logic                          tx_valid;
    logic [noc_pkg::FLIT_WIDTH-1:0] tx_data;
    logic                          tx_ready;

    // array port
    logic                          mem_we;
    logic                          mem_re;
    logic [ADDR_W-1:0]             mem_addr;
    logic [noc_pkg::FLIT_WIDTH-1:0] mem_wdata;
    logic [noc_pkg::FLIT_WIDTH-1:0] mem_rdata;

    noc_credit_in #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_noc_credit_in (
        .chip      (chip),
        .rst       (rst),
        .req_valid (req_valid),
        .req_data  (req_data),
        .req_yummy (req_yummy),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready)
    );

    mem_ctrl_fsm #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_mem_ctrl_fsm (
        .chip      (chip),
        .rst       (rst),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    mem_store #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_mem_store (
        .chip      (chip),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    noc_credit_out #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_noc_credit_out (
        .chip      (chip),
        .rst       (rst),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_yummy (rsp_yummy)
    );

endmodule

//--- src/mem_ctrl_fsm.sv
// fake memory controller fsm
// parses noc requests, accesses the word array, builds ack or nack replies

module mem_ctrl_fsm #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                          chip,
    input  logic                          rst,
    input  logic                          rx_valid,
    input  logic [noc_pkg::FLIT_WIDTH-1:0] rx_data,
    output logic                          rx_ready,
    output logic                          tx_valid,
    output logic [noc_pkg::FLIT_WIDTH-1:0] tx_data,
    input  logic                          tx_ready,
    output logic                          mem_we,
    output logic                          mem_re,
    output logic [$clog2(MEM_DEPTH)-1:0]  mem_addr,
    output logic [noc_pkg::FLIT_WIDTH-1:0] mem_wdata,
    input  logic [noc_pkg::FLIT_WIDTH-1:0] mem_rdata
);

    localparam int ADDR_W = $clog2(MEM_DEPTH);
    localparam int SRC_W  = noc_pkg::SRC_ID_HI - noc_pkg::SRC_ID_LO + 1;
    localparam int TYPE_W = noc_pkg::MSG_TYPE_HI - noc_pkg::MSG_TYPE_LO + 1;
    localparam int LEN_W  = noc_pkg::PAYLOAD_LEN_HI - noc_pkg::PAYLOAD_LEN_LO + 1;
    localparam int BYTE_W = noc_pkg::ADDR_HI - noc_pkg::ADDR_LO + 1;

    mem_pkg::mem_state_e state;
    mem_pkg::mem_state_e state_nxt;

    // captured request header
    logic [SRC_W-1:0]   src_id;
    logic [TYPE_W-1:0]  msg_type;    // raw opcode as received
    logic [LEN_W-1:0]   pay_len;
    logic [BYTE_W-1:0]  addr;
    logic [LEN_W-1:0]   pay_cnt;     // payload flits still to eat
    logic [noc_pkg::FLIT_WIDTH-1:0] data_reg;   // store data or load result

    logic               rx_fire;
    logic               is_load;
    logic               is_store;    // store with a data flit
    noc_pkg::msg_type_e rsp_type;
    logic [noc_pkg::FLIT_WIDTH-1:0] rsp_hdr;

    assign rx_fire  = rx_valid && rx_ready;
    assign is_load  = (msg_type == noc_pkg::MSG_LOAD_REQ);
    assign is_store = (msg_type == noc_pkg::MSG_STORE_REQ) && (pay_len != '0);

    // byte address shifted down to a word index modulo MEM_DEPTH
    assign mem_addr  = addr[mem_pkg::WORD_OFFSET_BITS +: ADDR_W];
    assign mem_wdata = data_reg;

    ////////////////////
    // reply header
    ////////////////////
    always_comb
    begin
        if (is_load)
            rsp_type = noc_pkg::MSG_LOAD_ACK;
        else if (is_store)
            rsp_type = noc_pkg::MSG_STORE_ACK;
        else
            rsp_type = noc_pkg::MSG_NACK;   // unknown type or empty store

        rsp_hdr = '0;
        rsp_hdr[noc_pkg::SRC_ID_HI:noc_pkg::SRC_ID_LO]           = src_id;
        rsp_hdr[noc_pkg::MSG_TYPE_HI:noc_pkg::MSG_TYPE_LO]       = rsp_type;
        rsp_hdr[noc_pkg::PAYLOAD_LEN_HI:noc_pkg::PAYLOAD_LEN_LO] = LEN_W'(is_load);
        rsp_hdr[noc_pkg::ADDR_HI:noc_pkg::ADDR_LO]               = addr;   // echo back
    end

    ////////////////////
    // next state, outputs
    ////////////////////
    always_comb
    begin
        state_nxt = state;
        rx_ready  = 1'b0;
        tx_valid  = 1'b0;
        tx_data   = rsp_hdr;
        mem_we    = 1'b0;
        mem_re    = 1'b0;
        case (state)
            mem_pkg::ST_HDR:
            begin
                rx_ready = 1'b1;
                if (rx_valid)
                begin
                    if (rx_data[noc_pkg::PAYLOAD_LEN_HI:noc_pkg::PAYLOAD_LEN_LO] != '0)
                        state_nxt = mem_pkg::ST_PAYLOAD;
                    else
                        state_nxt = mem_pkg::ST_ACCESS;
                end
            end
            mem_pkg::ST_PAYLOAD:
            begin
                rx_ready = 1'b1;
                if (rx_valid && (pay_cnt == LEN_W'(1)))
                    state_nxt = mem_pkg::ST_ACCESS;   // last data flit
            end
            mem_pkg::ST_ACCESS:
            begin
                mem_we = is_store;
                mem_re = is_load;
                state_nxt = is_load ? mem_pkg::ST_READ_WAIT : mem_pkg::ST_SEND_HDR;
            end
            mem_pkg::ST_READ_WAIT:
            begin
                state_nxt = mem_pkg::ST_SEND_HDR;
            end
            mem_pkg::ST_SEND_HDR:
            begin
                tx_valid = 1'b1;   // stalls here without credits
                if (tx_ready)
                    state_nxt = is_load ? mem_pkg::ST_SEND_DATA : mem_pkg::ST_HDR;
            end
            mem_pkg::ST_SEND_DATA:
            begin
                tx_valid = 1'b1;
                tx_data  = data_reg;
                if (tx_ready)
                    state_nxt = mem_pkg::ST_HDR;
            end
            default:
            begin
                state_nxt = mem_pkg::ST_HDR;
            end
        endcase
    end

    // header capture and data word
    always_ff @(posedge chip)
    begin
        if (rx_fire && (state == mem_pkg::ST_HDR))
        begin
            src_id   <= rx_data[noc_pkg::SRC_ID_HI:noc_pkg::SRC_ID_LO];
            msg_type <= rx_data[noc_pkg::MSG_TYPE_HI:noc_pkg::MSG_TYPE_LO];
            pay_len  <= rx_data[noc_pkg::PAYLOAD_LEN_HI:noc_pkg::PAYLOAD_LEN_LO];
            addr     <= rx_data[noc_pkg::ADDR_HI:noc_pkg::ADDR_LO];
        end
        // first payload flit of a store is the write word
        if (rx_fire && (state == mem_pkg::ST_PAYLOAD) && (pay_cnt == pay_len)
            && (msg_type == noc_pkg::MSG_STORE_REQ))
        begin
            data_reg <= rx_data;
        end
        if (state == mem_pkg::ST_READ_WAIT)
        begin
            data_reg <= mem_rdata;   // array output valid this cycle
        end
    end

    // state and payload counter
    always_ff @(posedge chip)
    begin
        if (rst)
        begin
            state   <= mem_pkg::ST_HDR;
            pay_cnt <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (rx_fire && (state == mem_pkg::ST_HDR))
                pay_cnt <= rx_data[noc_pkg::PAYLOAD_LEN_HI:noc_pkg::PAYLOAD_LEN_LO];
            else if (rx_fire && (state == mem_pkg::ST_PAYLOAD))
                pay_cnt <= pay_cnt - 1'b1;
        end
    end

endmodule

//--- src/mem_pkg.sv
// memory controller states and address to word mapping

package mem_pkg;

    ////////////////////
    // controller fsm
    ////////////////////
    typedef enum logic [2:0] {
        ST_HDR,         // wait for request header
        ST_PAYLOAD,     // eat data flits
        ST_ACCESS,      // one cycle array access
        ST_READ_WAIT,   // read data lands here
        ST_SEND_HDR,    // reply header out
        ST_SEND_DATA    // load data out
    } mem_state_e;

    ////////////////////
    // address mapping
    ////////////////////
    // 8 byte words, low three byte address bits ignored
    localparam int WORD_OFFSET_BITS = 3;

endpackage

//--- src/mem_store.sv
// word array backing the fake memory
// synchronous write, registered read one cycle after mem_re

module mem_store #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                              chip,
    input  logic                              mem_we,
    input  logic                              mem_re,
    input  logic [$clog2(MEM_DEPTH)-1:0]      mem_addr,
    input  logic [noc_pkg::FLIT_WIDTH-1:0]     mem_wdata,
    output logic [noc_pkg::FLIT_WIDTH-1:0]     mem_rdata
);

    logic [noc_pkg::FLIT_WIDTH-1:0] words [MEM_DEPTH];   // starts undefined

    always_ff @(posedge chip)
    begin
        if (mem_we)
        begin
            words[mem_addr] <= mem_wdata;
        end
        if (mem_re)
        begin
            mem_rdata <= words[mem_addr];   // valid next cycle
        end
    end

endmodule

//--- src/noc_credit_in.sv
// receive side of a credit link
// small flit FIFO with val/rdy out and one yummy per pop

module noc_credit_in #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                          chip,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic [noc_pkg::FLIT_WIDTH-1:0] req_data,
    output logic                          req_yummy,
    output logic                          rx_valid,
    output logic [noc_pkg::FLIT_WIDTH-1:0] rx_data,
    input  logic                          rx_ready
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [noc_pkg::FLIT_WIDTH-1:0] fifo_mem [BUF_DEPTH];   // flit storage
    logic [PTR_W-1:0]               wr_ptr;
    logic [PTR_W-1:0]               rd_ptr;
    logic [CNT_W-1:0]               count;                  // flits held
    logic                           push;
    logic                           pop;

    assign push     = req_valid;              // sender obeys credits so never overruns
    assign pop      = rx_valid && rx_ready;
    assign rx_valid = (count != '0);
    assign rx_data  = fifo_mem[rd_ptr];       // head of queue

    // flit storage write
    always_ff @(posedge chip)
    begin
        if (push)
        begin
            fifo_mem[wr_ptr] <= req_data;
        end
    end

    // pointers, occupancy and yummy
    always_ff @(posedge chip)
    begin
        if (rst)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            req_yummy <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // both or neither
            endcase
            req_yummy <= pop;                  // credit back one cycle after pop
        end
    end

endmodule

//--- src/noc_credit_out.sv
// send side of a credit link
// credit counter gates tx_ready, flit registered onto the link

module noc_credit_out #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                          chip,
    input  logic                          rst,
    input  logic                          tx_valid,
    input  logic [noc_pkg::FLIT_WIDTH-1:0] tx_data,
    output logic                          tx_ready,
    output logic                          rsp_valid,
    output logic [noc_pkg::FLIT_WIDTH-1:0] rsp_data,
    input  logic                          rsp_yummy
);

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [CNT_W-1:0] credits;   // 0 .. BUF_DEPTH
    logic             send;

    assign tx_ready = (credits != '0);
    assign send     = tx_valid && tx_ready;

    // output data register
    always_ff @(posedge chip)
    begin
        if (send)
        begin
            rsp_data <= tx_data;
        end
    end

    // valid pulse and credit count
    always_ff @(posedge chip)
    begin
        if (rst)
        begin
            rsp_valid <= 1'b0;
            credits   <= CNT_W'(BUF_DEPTH);   // receiver buffer starts empty
        end
        else
        begin
            rsp_valid <= send;                 // one cycle per flit
            case ({send, rsp_yummy})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // use and return cancel
            endcase
        end
    end

endmodule

//--- src/noc_pkg.sv
// noc flit width, message opcodes and header field positions
// shared by the link ports and the memory controller

package noc_pkg;

    ////////////////////
    // flit
    ////////////////////
    localparam int FLIT_WIDTH = 64;   // header layout below assumes 64 bits

    // message opcodes, 8 bits to fill the header field
    typedef enum logic [7:0] {
        MSG_LOAD_REQ  = 8'h01,
        MSG_STORE_REQ = 8'h02,
        MSG_LOAD_ACK  = 8'h11,
        MSG_STORE_ACK = 8'h12,
        MSG_NACK      = 8'hff
    } msg_type_e;

    ////////////////////
    // header fields
    ////////////////////
    localparam int SRC_ID_HI      = 63;   // requesting tile
    localparam int SRC_ID_LO      = 48;
    localparam int MSG_TYPE_HI    = 47;
    localparam int MSG_TYPE_LO    = 40;
    localparam int PAYLOAD_LEN_HI = 39;   // data flits after the header
    localparam int PAYLOAD_LEN_LO = 32;
    localparam int ADDR_HI        = 31;   // byte address
    localparam int ADDR_LO        = 0;

endpackage

//--- testbench/tb_fake_mem_table.svh
// request table for the fake memory testbench
// columns: src id, request type, payload len, byte addr, data slot, hold reply yummies, reply type

`ifndef TB_FAKE_MEM_TABLE_SVH
`define TB_FAKE_MEM_TABLE_SVH

typedef struct packed {
    logic [15:0]        src;
    logic [7:0]         mtype;      // raw opcode, may be unknown
    logic [7:0]         len;        // data flits after the header
    logic [31:0]        addr;       // byte address
    logic [2:0]         slot;       // random data word used
    logic               hold;       // reply yummies held while sent
    noc_pkg::msg_type_e exp_type;
} entry_t;

localparam logic [7:0]         REQ_LD  = noc_pkg::MSG_LOAD_REQ;
localparam logic [7:0]         REQ_ST  = noc_pkg::MSG_STORE_REQ;
localparam logic [7:0]         REQ_BAD = 8'h5a;   // no such opcode
localparam noc_pkg::msg_type_e ACK_LD  = noc_pkg::MSG_LOAD_ACK;
localparam noc_pkg::msg_type_e ACK_ST  = noc_pkg::MSG_STORE_ACK;
localparam noc_pkg::msg_type_e NACK    = noc_pkg::MSG_NACK;

entry_t tbl [32];
int     n_entries;

task automatic add_entry(input logic [15:0] src, input logic [7:0] mtype,
                         input logic [7:0] len, input logic [31:0] addr,
                         input logic [2:0] slot, input logic hold,
                         input noc_pkg::msg_type_e exp_type);
    tbl[n_entries] = {src, mtype, len, addr, slot, hold, exp_type};
    n_entries++;
endtask

task automatic fill_table();
    n_entries = 0;
    add_entry(16'h0001, REQ_ST,  8'd1, 32'h0000_0040, 3'd0, 1'b0, ACK_ST);
    add_entry(16'h0002, REQ_LD,  8'd0, 32'h0000_0040, 3'd0, 1'b0, ACK_LD);
    add_entry(16'h0003, REQ_LD,  8'd0, 32'h0000_0045, 3'd0, 1'b0, ACK_LD);  // low bits differ
    add_entry(16'h0004, REQ_LD,  8'd0, 32'h0000_0840, 3'd0, 1'b0, ACK_LD);  // +MEM_DEPTH words
    add_entry(16'h0005, REQ_ST,  8'd2, 32'h0000_01f8, 3'd1, 1'b0, ACK_ST);  // 2nd flit dropped
    add_entry(16'h0006, REQ_LD,  8'd0, 32'h0000_01f8, 3'd1, 1'b0, ACK_LD);
    add_entry(16'h0007, REQ_BAD, 8'd2, 32'h0000_0100, 3'd2, 1'b0, NACK);
    add_entry(16'h0008, REQ_ST,  8'd0, 32'h0000_0040, 3'd2, 1'b0, NACK);    // empty store
    add_entry(16'h0009, REQ_LD,  8'd0, 32'h0000_0040, 3'd0, 1'b0, ACK_LD);  // still old word
    add_entry(16'h000a, REQ_ST,  8'd1, 32'h0000_0080, 3'd3, 1'b0, ACK_ST);
    // held group, 8 request flits, fills both links
    add_entry(16'h0101, REQ_LD,  8'd0, 32'h0000_0080, 3'd3, 1'b1, ACK_LD);
    add_entry(16'h0102, REQ_LD,  8'd0, 32'h0000_0040, 3'd0, 1'b1, ACK_LD);
    add_entry(16'h0103, REQ_ST,  8'd1, 32'h0000_0300, 3'd4, 1'b1, ACK_ST);
    add_entry(16'h0104, REQ_LD,  8'd0, 32'h0000_0300, 3'd4, 1'b1, ACK_LD);
    add_entry(16'h0105, REQ_ST,  8'd1, 32'h0000_0308, 3'd5, 1'b1, ACK_ST);
    add_entry(16'h0106, REQ_LD,  8'd0, 32'h0000_0308, 3'd5, 1'b1, ACK_LD);
    add_entry(16'h0201, REQ_LD,  8'd0, 32'h0000_01ff, 3'd1, 1'b0, ACK_LD);  // release
    add_entry(16'h0202, REQ_LD,  8'd0, 32'h0000_1080, 3'd3, 1'b0, ACK_LD);  // +2*MEM_DEPTH
endtask

`endif

//--- testbench/tb_fake_mem.sv
// testbench for the fake memory top
// credit models on both links, table driven requests, in order reply checks

module tb_fake_mem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BUF_DEPTH = 4;
    localparam int MEM_DEPTH = 256;
    localparam int LOG_SIZE  = 64;    // reply flits kept
    localparam int TIMEOUT   = 400;   // cycles per wait
    localparam int FW        = noc_pkg::FLIT_WIDTH;

    logic          chip = 1'b0;
    logic          rst;
    logic          req_valid;
    logic [FW-1:0] req_data;
    logic          req_yummy;
    logic          rsp_valid;
    logic [FW-1:0] rsp_data;
    logic          rsp_yummy;

    logic [FW-1:0] slot_word [8];          // random store data
    logic [FW-1:0] exp_log [LOG_SIZE];     // expected reply flits
    logic [FW-1:0] rsp_log [LOG_SIZE];     // reply flits seen
    int            seed;
    int            sent_cnt;               // request flits sent
    int            yummy_cnt;              // req_yummy pulses seen
    int            rsp_seen;
    int            rsp_given;              // rsp_yummy pulses given
    int            exp_count;
    int            checked;
    logic          hold_yummies;

    `include "tb_fake_mem_table.svh"

    fake_mem_top #(
        .BUF_DEPTH (BUF_DEPTH),
        .MEM_DEPTH (MEM_DEPTH)
    ) i_fake_mem_top (
        .chip      (chip),
        .rst       (rst),
        .req_valid (req_valid),
        .req_data  (req_data),
        .req_yummy (req_yummy),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_yummy (rsp_yummy)
    );

    always #10 chip = ~chip;   // 20 ns

    ////////////////////
    // helpers
    ////////////////////
    task automatic stop_on_error();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        stop_on_error();
    endtask

    task automatic check_value(input string name, input logic [FW-1:0] got, exp);
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic next_cycle();
        @(posedge chip);
        #2;                                  // drive point
    endtask

    // one flit once a sender credit is free
    task automatic send_flit(input logic [FW-1:0] flit);
        int waited;
        waited = 0;
        while (sent_cnt - yummy_cnt >= BUF_DEPTH)
        begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT)
                timed_out("a request link credit on req_yummy");
        end
        req_valid = 1'b1;
        req_data  = flit;
        sent_cnt++;
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic send_request(input entry_t e);
        send_flit({e.src, e.mtype, e.len, e.addr});
        for (int k = 0; k < int'(e.len); k++)
            send_flit((k == 0) ? slot_word[e.slot] : ~slot_word[e.slot]);  // extras differ
    endtask

    // reply header echoes src and addr with len 1 only for a load ack
    task automatic expect_reply(input entry_t e);
        exp_log[exp_count] = {e.src, e.exp_type, (e.exp_type == ACK_LD) ? 8'd1 : 8'd0, e.addr};
        exp_count++;
        if (e.exp_type == ACK_LD)
        begin
            exp_log[exp_count] = slot_word[e.slot];
            exp_count++;
        end
    endtask

    task automatic check_replies();
        int waited;
        waited = 0;
        while (rsp_seen < exp_count)
        begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT)
                timed_out("reply flits on rsp_valid");
        end
        while (checked < exp_count)
        begin
            check_value($sformatf("rsp_data flit %0d", checked), rsp_log[checked],
                        exp_log[checked]);
            checked++;
        end
    endtask

    ////////////////////
    // link monitor
    ////////////////////
    initial
    begin
        rsp_seen  = 0;
        yummy_cnt = 0;
        forever
        begin
            @(negedge chip);                 // registered outputs settled
            if (rsp_valid === 1'b1)
            begin
                assert (rsp_seen < LOG_SIZE)
                else
                begin
                    $display("more reply flits than the log can hold");
                    stop_on_error();
                end
                rsp_log[rsp_seen] = rsp_data;
                rsp_seen++;
                assert (rsp_seen - rsp_given <= BUF_DEPTH)
                else
                begin
                    $display("CHECK FAILED rsp_valid outstanding %h credits %h",
                             rsp_seen - rsp_given, BUF_DEPTH);
                    stop_on_error();
                end
            end
            if (req_yummy === 1'b1)
                yummy_cnt++;
        end
    end

    // reply receiver gives one yummy per flit unless held
    initial
    begin
        rsp_yummy = 1'b0;
        rsp_given = 0;
        forever
        begin
            next_cycle();
            if (!hold_yummies && (rsp_given < rsp_seen))
            begin
                rsp_yummy = 1'b1;
                rsp_given++;
            end
            else
                rsp_yummy = 1'b0;
        end
    end

    ////////////////////
    // main sequence
    ////////////////////
    initial
    begin
        entry_t e;
        int     waited;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_data     = '0;
        hold_yummies = 1'b0;
        sent_cnt     = 0;
        exp_count    = 0;
        checked      = 0;
        seed         = 32'h2;
        for (int i = 0; i < 8; i++)
            slot_word[i] = {$random(seed), $random(seed)};
        fill_table();

        repeat (10) @(posedge chip);
        #2;
        rst = 1'b0;

        // quiet links before any request
        repeat (20)
        begin
            next_cycle();
            check_value("rsp_valid", 64'(rsp_valid), 64'd0);
            check_value("req_yummy", 64'(req_yummy), 64'd0);
        end

        for (int i = 0; i < n_entries; i++)
        begin
            e = tbl[i];
            if (e.hold && !hold_yummies)
            begin
                waited = 0;
                while (rsp_given != rsp_seen)    // all reply credits back first
                begin
                    next_cycle();
                    waited++;
                    if (waited > TIMEOUT)
                        timed_out("reply yummies before the held group");
                end
                hold_yummies = 1'b1;
            end
            else if (!e.hold && hold_yummies)
            begin
                repeat (40) next_cycle();        // let the reply link stall
                check_value("rsp flits held", 64'(rsp_seen - rsp_given), 64'(BUF_DEPTH));
                hold_yummies = 1'b0;
            end
            send_request(e);
            expect_reply(e);
            if (!e.hold)
                check_replies();
        end

        // every request flit credited back
        waited = 0;
        while (yummy_cnt != sent_cnt)
        begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT)
                timed_out("req_yummy for all sent flits");
        end
        repeat (20) next_cycle();
        check_value("req_yummy count", 64'(yummy_cnt), 64'(sent_cnt));
        check_value("reply flit count", 64'(rsp_seen), 64'(exp_count));

        $display("RESULT: PASS");
        $finish;
    end

endmodule
